/* bench/devil_core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "devil_macros.svh"

module devil_core_tb
    import devil_pkg::*;
();

    localparam int CLK_NS          = 40;
    localparam int NUM_ROWS        = 13;
    localparam int MAX_DELAY       = 12;
    localparam int REG_ACCESSES    = 80;
    // per row budget plus the register setup and readback phase
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (16 + MAX_DELAY + 40) + 3 * REG_ACCESSES + 20;

    // one snoop scenario, offset only used when present is set
    typedef struct packed {
        logic [1:0]  cmd;
        logic [4:0]  psize;
        logic        present;
        logic [3:0]  offset;
        logic [15:0] mask;
        logic [15:0] delay;
        logic [3:0]  hold;
    } case_row_t;

    logic        ace_aclk = 1'b0;
    logic        ace_aresetn;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        trigger;
    snoop_cap_t  snoop;
    logic        wr_valid;
    wr_snoop_t   wr;
    logic        wr_done;
    logic        reply_valid;
    cache_line_u reply_line;
    logic        reply_ack;

    case_row_t   rows [NUM_ROWS];
    int          n_rows;
    int          checks;
    int          errors;
    int          stalls;
    logic [31:0] lcg_state;
    // copies of the line windows written over apb
    cache_line_u exp_pattern;
    cache_line_u exp_tamper;

    always #(CLK_NS / 2) ace_aclk = ~ace_aclk;

    devil_core dut_i (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_apb         (apb_req),
        .o_apb         (apb_rsp),
        .i_trigger     (trigger),
        .i_snoop       (snoop),
        .o_wr_valid    (wr_valid),
        .o_wr          (wr),
        .i_wr_done     (wr_done),
        .o_reply_valid (reply_valid),
        .o_reply_line  (reply_line),
        .i_reply_ack   (reply_ack)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // scalar registers sit back to back from offset 0x00
    function automatic logic [31:0] field_mask(input int idx);
        case (idx)
            0:       return 32'h0000_0003;
            1:       return 32'h0000_001f;
            2:       return 32'h0000_ffff;
            3:       return 32'h0000_ffff;
            4:       return 32'hffff_ffff;
            default: return 32'h0000_0007;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [639:0] actual,
                               input logic [639:0] expected);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("ERR %0t: %s mismatch, got %0h expected %0h", $time, what, actual, expected);
        end
    endtask

    // one apb transfer, setup then access, response taken mid access phase
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(posedge ace_aclk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge ace_aclk);
        apb_req.penable <= 1'b1;
        @(negedge ace_aclk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_value("pready in access phase", apb_rsp.pready, 1'b1);
        @(posedge ace_aclk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check_value("pslverr on write", err, 1'b0);
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_value("pslverr on read", err, 1'b0);
    endtask

    task automatic add_row(input logic [1:0] cmd, input logic [4:0] psize,
                           input logic present, input logic [3:0] offset,
                           input logic [15:0] mask, input logic [15:0] delay,
                           input logic [3:0] hold);
        case_row_t r;
        r.cmd     = cmd;
        r.psize   = psize;
        r.present = present;
        r.offset  = offset;
        r.mask    = mask;
        r.delay   = delay;
        r.hold    = hold;
        rows[n_rows] = r;
        n_rows = n_rows + 1;
    endtask

    // ------------------------------------------------------------
    // case table: cmd, size, present, offset, mask, delay, hold
    // ------------------------------------------------------------
    task automatic fill_table();
        n_rows = 0;
        add_row(2'd3,              4,  1'b1, 4'd2,  16'hffff, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_TAMPER, 3,  1'b0, 4'd0,  16'hffff, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_TAMPER, 0,  1'b1, 4'd0,  16'hffff, 16'd0,  4'd1);
        add_row(`DEVIL_CMD_TAMPER, 4,  1'b1, 4'd0,  16'h00f3, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_TAMPER, 5,  1'b1, 4'd6,  16'ha5c3, 16'd0,  4'd4);
        add_row(`DEVIL_CMD_TAMPER, 3,  1'b1, 4'd13, 16'hffff, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_TAMPER, 16, 1'b1, 4'd0,  16'h8001, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_DELAY,  2,  1'b1, 4'd9,  16'h0000, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_DELAY,  4,  1'b1, 4'd5,  16'h0000, 16'd12, 4'd2);
        add_row(`DEVIL_CMD_POISON, 6,  1'b1, 4'd10, 16'h0000, 16'd0,  4'd3);
        add_row(`DEVIL_CMD_POISON, 2,  1'b0, 4'd0,  16'h0000, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_TAMPER, 17, 1'b0, 4'd0,  16'hffff, 16'd0,  4'd0);
        add_row(`DEVIL_CMD_DELAY,  1,  1'b1, 4'd15, 16'h0000, 16'd3,  4'd0);
    endtask

    // write every register, read all back, then probe unmapped offsets
    task automatic test_registers();
        logic [31:0] vals [6];
        logic [31:0] rdata;
        logic        err;
        for (int i = 0; i < 6; i++)
        begin
            vals[i] = lcg_next();
            write_reg(8'(4 * i), vals[i]);
        end
        for (int w = 0; w < 16; w++)
        begin
            exp_pattern.word[w] = lcg_next();
            exp_tamper.word[w]  = lcg_next();
            write_reg(`DEVIL_REG_PATTERN_BASE + 8'(4 * w), exp_pattern.word[w]);
            write_reg(`DEVIL_REG_TAMPER_BASE + 8'(4 * w), exp_tamper.word[w]);
        end
        for (int i = 0; i < 6; i++)
        begin
            read_reg(8'(4 * i), rdata);
            check_value("scalar register readback", rdata, vals[i] & field_mask(i));
        end
        for (int w = 0; w < 16; w++)
        begin
            read_reg(`DEVIL_REG_PATTERN_BASE + 8'(4 * w), rdata);
            check_value("pattern word readback", rdata, exp_pattern.word[w]);
            read_reg(`DEVIL_REG_TAMPER_BASE + 8'(4 * w), rdata);
            check_value("tamper word readback", rdata, exp_tamper.word[w]);
        end
        // gap after the scalars, hole below the pattern window, odd byte offset
        apb_access(1'b0, 8'h18, 32'h0, rdata, err);
        check_value("pslverr at 0x18", err, 1'b1);
        check_value("prdata at 0x18", rdata, 32'h0);
        apb_access(1'b0, 8'h3c, 32'h0, rdata, err);
        check_value("pslverr at 0x3c", err, 1'b1);
        check_value("prdata at 0x3c", rdata, 32'h0);
        apb_access(1'b0, 8'h42, 32'h0, rdata, err);
        check_value("pslverr at 0x42", err, 1'b1);
        check_value("prdata at 0x42", rdata, 32'h0);
    endtask

    // falling edges until either handshake shows up, or the limit
    task automatic wait_handshake(input int limit, output int cycles);
        logic seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && (cycles < limit))
        begin
            @(negedge ace_aclk);
            cycles = cycles + 1;
            seen   = wr_valid || reply_valid;
        end
    endtask

    // ------------------------------------------------------------
    // one snoop from the table, config through reply
    // ------------------------------------------------------------
    task automatic run_row(input int idx);
        case_row_t   r;
        cache_line_u line;
        cache_line_u exp_line;
        wr_snoop_t   exp_wr;
        logic [31:0] waddr;
        logic [31:0] tmp;
        logic [43:0] acaddr;
        logic        hit;
        logic        exp_poison;
        int          cycles;
        int          limit;
        r     = rows[idx];
        waddr = lcg_next();
        tmp   = lcg_next();
        write_reg(`DEVIL_REG_CMD, {30'h0, r.cmd});
        write_reg(`DEVIL_REG_PSIZE, {27'h0, r.psize});
        write_reg(`DEVIL_REG_MASK, {16'h0, r.mask});
        write_reg(`DEVIL_REG_DELAY, {16'h0, r.delay});
        write_reg(`DEVIL_REG_WADDR, waddr);
        write_reg(`DEVIL_REG_AWSNOOP, {29'h0, tmp[2:0]});
        exp_wr.awaddr  = {12'h0, waddr};
        exp_wr.awsnoop = tmp[2:0];
        exp_wr.line    = exp_tamper;
        // random line with the pattern planted where the row asks
        for (int w = 0; w < 16; w++)
            line.word[w] = lcg_next();
        hit = r.present && (r.psize != 0) && (r.psize <= 16) && (r.offset + r.psize <= 16);
        if (hit)
        begin
            for (int j = 0; j < r.psize; j++)
                line.word[r.offset + j] = exp_pattern.word[j];
        end
        exp_line = line;
        if (hit && (r.cmd == `DEVIL_CMD_TAMPER))
        begin
            for (int w = 0; w < 16; w++)
            begin
                if (r.mask[w])
                    exp_line.word[w] = exp_tamper.word[w];
            end
        end
        exp_poison = hit && (r.cmd == `DEVIL_CMD_POISON);
        tmp    = lcg_next();
        acaddr = {tmp[11:0], lcg_next()};
        @(posedge ace_aclk);
        trigger      <= 1'b1;
        snoop.acaddr <= acaddr;
        snoop.line   <= line;
        @(posedge ace_aclk);
        trigger <= 1'b0;
        limit = 16 + r.delay + 20;
        wait_handshake(limit, cycles);
        if (!(wr_valid || reply_valid))
        begin
            $display("row %0d got no write request and no reply within %0d cycles", idx, limit);
            stalls = stalls + 1;
            return;
        end
        check_value("write request present", wr_valid, exp_poison);
        if (wr_valid)
        begin
            check_value("o_wr", wr, exp_wr);
            // request must hold and the reply wait until wr_done
            repeat (r.hold)
            begin
                @(negedge ace_aclk);
                check_value("o_wr_valid held", wr_valid, 1'b1);
                check_value("o_wr held", wr, exp_wr);
                check_value("o_reply_valid before wr done", reply_valid, 1'b0);
            end
            @(posedge ace_aclk);
            wr_done <= 1'b1;
            @(posedge ace_aclk);
            wr_done <= 1'b0;
            wait_handshake(limit, cycles);
            if (!reply_valid)
            begin
                $display("row %0d got no reply within %0d cycles after wr done", idx, limit);
                stalls = stalls + 1;
                return;
            end
        end
        // cycles counted from the edge that took the trigger
        if (hit && (r.cmd == `DEVIL_CMD_DELAY))
            check_value("reply not before delay+1", (cycles - 1) >= (r.delay + 1), 1'b1);
        check_value("o_reply_line", reply_line, exp_line);
        repeat (r.hold)
        begin
            @(negedge ace_aclk);
            check_value("o_reply_valid held", reply_valid, 1'b1);
            check_value("o_reply_line held", reply_line, exp_line);
        end
        @(posedge ace_aclk);
        reply_ack <= 1'b1;
        @(posedge ace_aclk);
        reply_ack <= 1'b0;
        @(negedge ace_aclk);
        check_value("o_reply_valid after ack", reply_valid, 1'b0);
        check_value("o_wr_valid after ack", wr_valid, 1'b0);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial
    begin
        apb_req     <= '0;
        trigger     <= 1'b0;
        snoop       <= '0;
        wr_done     <= 1'b0;
        reply_ack   <= 1'b0;
        ace_aresetn <= 1'b0;
        lcg_state = 32'hfdae4355;
        checks    = 0;
        errors    = 0;
        stalls    = 0;
        fill_table();
        repeat (4) @(posedge ace_aclk);
        ace_aresetn <= 1'b1;
        @(negedge ace_aclk);
        // handshake outputs quiet out of reset
        check_value("o_reply_valid after reset", reply_valid, 1'b0);
        check_value("o_wr_valid after reset", wr_valid, 1'b0);
        check_value("pready after reset", apb_rsp.pready, 1'b0);
        check_value("pslverr after reset", apb_rsp.pslverr, 1'b0);
        test_registers();
        for (int i = 0; i < n_rows; i++)
            run_row(i);
        repeat (2) @(posedge ace_aclk);
        $display("checks %0d, value errors %0d, handshake errors %0d", checks, errors, stalls);
        if ((errors == 0) && (stalls == 0))
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog sized from the table length and the longest delay
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("timeout, the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/devil_pkg.sv
hdl/devil_cfg_regs.sv
hdl/devil_pattern_match.sv
hdl/devil_ctrl.sv
hdl/devil_core.sv
bench/devil_core_tb.sv

/* hdl/devil_cfg_regs.sv */
`timescale 1ns/100ps
`default_nettype none

`include "devil_macros.svh"

module devil_cfg_regs
    import devil_pkg::*;
(
    input  wire        ace_aclk,
    input  wire        ace_aresetn,
    input  wire        apb_req_t i_apb,
    output apb_rsp_t   o_apb,
    output devil_cfg_t o_cfg
);

    // ------------------------------------------------------------
    // scalar registers
    // ------------------------------------------------------------
    logic [1:0]                   cmd_q;
    logic [4:0]                   psize_q;
    logic [`DEVIL_LINE_WORDS-1:0] mask_q;
    logic [`DEVIL_DELAY_BITS-1:0] delay_q;
    logic [`DEVIL_WORD_BITS-1:0]  waddr_q;
    logic [2:0]                   awsnoop_q;

    // line windows written one word at a time
    cache_line_u pattern_q;
    cache_line_u tamper_q;

    logic                        access;
    logic                        wr_en;
    logic                        sel_pat;
    logic                        sel_tam;
    logic                        mapped;
    logic [3:0]                  word_idx;
    logic [`DEVIL_WORD_BITS-1:0] rdata;

    // access phase has psel and penable both high
    assign access   = i_apb.psel && i_apb.penable;
    assign sel_pat  = (i_apb.paddr & `DEVIL_REG_BLOCK_MASK) == `DEVIL_REG_PATTERN_BASE;
    assign sel_tam  = (i_apb.paddr & `DEVIL_REG_BLOCK_MASK) == `DEVIL_REG_TAMPER_BASE;
    assign word_idx = i_apb.paddr[5:2];
    assign wr_en    = access && i_apb.pwrite && mapped;

    // ------------------------------------------------------------
    // address decode and readback mux
    // ------------------------------------------------------------
    always_comb
    begin
        rdata  = '0;
        mapped = 1'b1;
        if (sel_pat)
            rdata = pattern_q.word[word_idx];
        else if (sel_tam)
            rdata = tamper_q.word[word_idx];
        else
        begin
            case (i_apb.paddr)
                `DEVIL_REG_CMD:     rdata[1:0]                   = cmd_q;
                `DEVIL_REG_PSIZE:   rdata[4:0]                   = psize_q;
                `DEVIL_REG_MASK:    rdata[`DEVIL_LINE_WORDS-1:0] = mask_q;
                `DEVIL_REG_DELAY:   rdata[`DEVIL_DELAY_BITS-1:0] = delay_q;
                `DEVIL_REG_WADDR:   rdata                        = waddr_q;
                `DEVIL_REG_AWSNOOP: rdata[2:0]                   = awsnoop_q;
                default:            mapped                       = 1'b0;
            endcase
        end
        // byte offsets inside a word are not decoded
        if (i_apb.paddr[1:0] != 2'b00)
        begin
            mapped = 1'b0;
            rdata  = '0;
        end
    end

    // zero wait states with the error flagged in the same access phase
    assign o_apb.pready  = access;
    assign o_apb.pslverr = access && !mapped;
    assign o_apb.prdata  = (access && !i_apb.pwrite) ? rdata : '0;

    // ------------------------------------------------------------
    // register writes take effect at the end of the access phase
    // ------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            cmd_q     <= '0;
            psize_q   <= '0;
            mask_q    <= '0;
            delay_q   <= '0;
            waddr_q   <= '0;
            awsnoop_q <= '0;
        end
        else if (wr_en)
        begin
            case (i_apb.paddr)
                `DEVIL_REG_CMD:     cmd_q     <= i_apb.pwdata[1:0];
                `DEVIL_REG_PSIZE:   psize_q   <= i_apb.pwdata[4:0];
                `DEVIL_REG_MASK:    mask_q    <= i_apb.pwdata[`DEVIL_LINE_WORDS-1:0];
                `DEVIL_REG_DELAY:   delay_q   <= i_apb.pwdata[`DEVIL_DELAY_BITS-1:0];
                `DEVIL_REG_WADDR:   waddr_q   <= i_apb.pwdata;
                `DEVIL_REG_AWSNOOP: awsnoop_q <= i_apb.pwdata[2:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (wr_en && sel_pat)
            pattern_q.word[word_idx] <= i_apb.pwdata;
        if (wr_en && sel_tam)
            tamper_q.word[word_idx] <= i_apb.pwdata;
    end

    assign o_cfg = '{
        cmd:          cmd_q,
        pattern_size: psize_q,
        word_mask:    mask_q,
        delay:        delay_q,
        wr_addr:      waddr_q,
        awsnoop:      awsnoop_q,
        pattern:      pattern_q,
        tamper:       tamper_q
    };

    // an errored access returns zero data
    a_slverr_zero_data: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_apb.pslverr |-> (o_apb.prdata == '0));

endmodule

`default_nettype wire

/* hdl/devil_core.sv */
`timescale 1ns/100ps
`default_nettype none

module devil_core
    import devil_pkg::*;
(
    input  wire              ace_aclk,
    input  wire              ace_aresetn,
    // config bus
    input  wire apb_req_t    i_apb,
    output apb_rsp_t         o_apb,
    // captured snoop
    input  wire              i_trigger,
    input  wire snoop_cap_t  i_snoop,
    // write-snoop request
    output logic             o_wr_valid,
    output wr_snoop_t        o_wr,
    input  wire              i_wr_done,
    // snoop reply
    output logic             o_reply_valid,
    output cache_line_u      o_reply_line,
    input  wire              i_reply_ack
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    devil_cfg_t  cfg;
    cache_line_u match_line;
    logic        match_start;
    logic        match_done;
    logic        match_hit;

    devil_cfg_regs cfg_i (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .o_cfg       (cfg)
    );

    // hit offset is not needed by the controller
    devil_pattern_match match_i (
        .ace_aclk       (ace_aclk),
        .ace_aresetn    (ace_aresetn),
        .i_start        (match_start),
        .i_pattern      (cfg.pattern),
        .i_pattern_size (cfg.pattern_size),
        .i_line         (match_line),
        .o_done         (match_done),
        .o_hit          (match_hit),
        .o_offset       ()
    );

    devil_ctrl ctrl_i (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_trigger     (i_trigger),
        .i_snoop       (i_snoop),
        .i_cfg         (cfg),
        .o_match_start (match_start),
        .o_match_line  (match_line),
        .i_match_done  (match_done),
        .i_match_hit   (match_hit),
        .o_wr_valid    (o_wr_valid),
        .o_wr          (o_wr),
        .i_wr_done     (i_wr_done),
        .o_reply_valid (o_reply_valid),
        .o_reply_line  (o_reply_line),
        .i_reply_ack   (i_reply_ack)
    );

endmodule

`default_nettype wire

/* hdl/devil_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "devil_macros.svh"

module devil_ctrl
    import devil_pkg::*;
(
    input  wire              ace_aclk,
    input  wire              ace_aresetn,
    input  wire              i_trigger,
    input  wire snoop_cap_t  i_snoop,
    input  wire devil_cfg_t  i_cfg,
    output logic             o_match_start,
    output cache_line_u      o_match_line,
    input  wire              i_match_done,
    input  wire              i_match_hit,
    output logic             o_wr_valid,
    output wr_snoop_t        o_wr,
    input  wire              i_wr_done,
    output logic             o_reply_valid,
    output cache_line_u      o_reply_line,
    input  wire              i_reply_ack
);

    // ------------------------------------------------------------
    // fsm states
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        s_idle,
        s_match,
        s_dispatch,
        s_tamper,
        s_delay,
        s_poison,
        s_reply
    } ctrl_state_t;

    ctrl_state_t                  state_q;
    logic [`DEVIL_DELAY_BITS-1:0] cnt_q;
    cache_line_u                  line_q;
    wr_snoop_t                    wr_q;
    logic                         hit_done;

    // result of a scan that found the pattern
    assign hit_done = (state_q == s_dispatch) && i_match_done && i_match_hit;

    // start pulse is the single match cycle
    assign o_match_start = (state_q == s_match);
    assign o_match_line  = line_q;
    assign o_wr_valid    = (state_q == s_poison);
    assign o_wr          = wr_q;
    assign o_reply_valid = (state_q == s_reply);
    assign o_reply_line  = line_q;

    // ------------------------------------------------------------
    // state and delay counter
    // ------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            state_q <= s_idle;
            cnt_q   <= '0;
        end
        else
        begin
            case (state_q)
                s_idle:
                    if (i_trigger)
                        state_q <= s_match;
                s_match:
                    state_q <= s_dispatch;
                s_dispatch:
                begin
                    // a miss goes straight to the reply
                    if (i_match_done && !i_match_hit)
                        state_q <= s_reply;
                    else if (hit_done)
                    begin
                        case (i_cfg.cmd)
                            `DEVIL_CMD_TAMPER: state_q <= s_tamper;
                            `DEVIL_CMD_POISON: state_q <= s_poison;
                            `DEVIL_CMD_DELAY:
                            begin
                                // zero delay replies on the next cycle
                                cnt_q   <= i_cfg.delay;
                                state_q <= (i_cfg.delay == '0) ? s_reply : s_delay;
                            end
                            default: state_q <= s_reply;
                        endcase
                    end
                end
                // merge happens on this edge
                s_tamper:
                    state_q <= s_reply;
                s_delay:
                begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == 'd1)
                        state_q <= s_reply;
                end
                s_poison:
                    if (i_wr_done)
                        state_q <= s_reply;
                s_reply:
                    if (i_reply_ack)
                        state_q <= s_idle;
                default:
                    state_q <= s_idle;
            endcase
        end
    end

    // ------------------------------------------------------------
    // line capture, tamper merge and poison request
    // ------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if ((state_q == s_idle) && i_trigger)
            line_q <= i_snoop.line;
        else if (state_q == s_tamper)
        begin
            // word granular merge where the mask bit selects the tamper word
            for (int w = 0; w < `DEVIL_LINE_WORDS; w++)
            begin
                if (i_cfg.word_mask[w])
                    line_q.word[w] <= i_cfg.tamper.word[w];
            end
        end
        // latched so apb writes cannot disturb a pending request
        if (hit_done && (i_cfg.cmd == `DEVIL_CMD_POISON))
        begin
            wr_q.awaddr  <= {{(`DEVIL_SNOOP_ADDR_BITS-`DEVIL_WORD_BITS){1'b0}}, i_cfg.wr_addr};
            wr_q.awsnoop <= i_cfg.awsnoop;
            wr_q.line    <= i_cfg.tamper;
        end
    end

    // write request holds its payload until wr_done
    a_wr_stable: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_wr_valid && !i_wr_done) |=> (o_wr_valid && $stable(o_wr)));

    // reply holds its line until it is acknowledged
    a_reply_stable: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        (o_reply_valid && !i_reply_ack) |=> (o_reply_valid && $stable(o_reply_line)));

endmodule

`default_nettype wire

/* hdl/devil_macros.svh */
`ifndef DEVIL_MACROS_SVH
`define DEVIL_MACROS_SVH

// ------------------------------------------------------------
// line geometry, fixed by the coherence protocol
// ------------------------------------------------------------
`define DEVIL_WORD_BITS         32
`define DEVIL_LINE_WORDS        16
`define DEVIL_LINE_BITS         512
`define DEVIL_ADDR_BITS         8
`define DEVIL_SNOOP_ADDR_BITS   44
`define DEVIL_DELAY_BITS        16

// command codes, code 3 falls through to a plain reply
`define DEVIL_CMD_TAMPER        2'd0
`define DEVIL_CMD_POISON        2'd1
`define DEVIL_CMD_DELAY         2'd2

// ------------------------------------------------------------
// register map, byte offsets on the config bus
// ------------------------------------------------------------
`define DEVIL_REG_CMD           8'h00
`define DEVIL_REG_PSIZE         8'h04
`define DEVIL_REG_MASK          8'h08
`define DEVIL_REG_DELAY         8'h0C
`define DEVIL_REG_WADDR         8'h10
`define DEVIL_REG_AWSNOOP       8'h14
`define DEVIL_REG_PATTERN_BASE  8'h40
`define DEVIL_REG_TAMPER_BASE   8'h80
// upper address bits select one of the 64-byte line windows
`define DEVIL_REG_BLOCK_MASK    8'hC0

`endif

/* hdl/devil_pattern_match.sv */
`timescale 1ns/100ps
`default_nettype none

`include "devil_macros.svh"

module devil_pattern_match
    import devil_pkg::*;
(
    input  wire              ace_aclk,
    input  wire              ace_aresetn,
    input  wire              i_start,
    input  wire cache_line_u i_pattern,
    input  wire [4:0]        i_pattern_size,
    input  wire cache_line_u i_line,
    output logic             o_done,
    output logic             o_hit,
    output logic [3:0]       o_offset
);

    // ------------------------------------------------------------
    // scan state for one word offset per cycle
    // ------------------------------------------------------------
    logic       busy_q;
    logic [3:0] off_q;
    logic [3:0] cur_off;
    logic [4:0] last_off;
    logic [4:0] idx;
    logic       size_ok;
    logic       scan_act;
    logic       cmp_hit;

    // sizes 0 and above 16 never match
    assign size_ok  = (i_pattern_size != 5'd0) && (i_pattern_size <= 5'd16);
    assign last_off = 5'd16 - i_pattern_size;

    // offset 0 is tested in the start cycle itself
    assign cur_off  = i_start ? 4'd0 : off_q;
    assign scan_act = i_start || busy_q;

    // full compare of pattern words 0..size-1 at cur_off
    always_comb
    begin
        cmp_hit = size_ok;
        idx     = '0;
        for (int j = 0; j < `DEVIL_LINE_WORDS; j++)
        begin
            idx = {1'b0, cur_off} + 5'(j);
            // words past the pattern size do not take part
            if ((5'(j) < i_pattern_size) && (i_pattern.word[j] != i_line.word[idx[3:0]]))
                cmp_hit = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // offset walk ends on the first hit or after the last fit
    // ------------------------------------------------------------
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            busy_q   <= 1'b0;
            off_q    <= '0;
            o_done   <= 1'b0;
            o_hit    <= 1'b0;
            o_offset <= '0;
        end
        else
        begin
            // single-cycle result pulse
            o_done <= 1'b0;
            o_hit  <= 1'b0;
            if (scan_act)
            begin
                if (!size_ok || cmp_hit || ({1'b0, cur_off} == last_off))
                begin
                    busy_q   <= 1'b0;
                    o_done   <= 1'b1;
                    o_hit    <= cmp_hit;
                    o_offset <= cur_off;
                end
                else
                begin
                    busy_q <= 1'b1;
                    off_q  <= cur_off + 4'd1;
                end
            end
        end
    end

    // a reported hit never lets the pattern run past the end of the line
    a_hit_fits: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        o_hit |-> (({1'b0, o_offset} + i_pattern_size) <= 5'd16));

    // the controller waits for done before it starts again
    a_no_start_while_busy: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        i_start |-> !busy_q);

endmodule

`default_nettype wire

/* hdl/devil_pkg.sv */
`default_nettype none

`include "devil_macros.svh"

package devil_pkg;

    // ------------------------------------------------------------
    // cache line, seen flat or as sixteen words
    // ------------------------------------------------------------
    typedef union packed {
        logic [`DEVIL_LINE_BITS-1:0]                        flat;
        logic [`DEVIL_LINE_WORDS-1:0][`DEVIL_WORD_BITS-1:0] word;
    } cache_line_u;

    // apb request, master to slave
    typedef struct packed {
        logic                        psel;
        logic                        penable;
        logic                        pwrite;
        logic [`DEVIL_ADDR_BITS-1:0] paddr;
        logic [`DEVIL_WORD_BITS-1:0] pwdata;
    } apb_req_t;

    // apb response, zero wait states
    typedef struct packed {
        logic [`DEVIL_WORD_BITS-1:0] prdata;
        logic                        pready;
        logic                        pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------
    // configuration as seen by matcher and controller
    // ------------------------------------------------------------
    typedef struct packed {
        logic [1:0]                   cmd;
        logic [4:0]                   pattern_size;
        logic [`DEVIL_LINE_WORDS-1:0] word_mask;
        logic [`DEVIL_DELAY_BITS-1:0] delay;
        logic [`DEVIL_WORD_BITS-1:0]  wr_addr;
        logic [2:0]                   awsnoop;
        cache_line_u                  pattern;
        // tamper words, also the poison payload
        cache_line_u                  tamper;
    } devil_cfg_t;

    // snoop snapshot, valid with the trigger pulse
    typedef struct packed {
        logic [`DEVIL_SNOOP_ADDR_BITS-1:0] acaddr;
        cache_line_u                       line;
    } snoop_cap_t;

    // write-snoop request towards the active side
    typedef struct packed {
        logic [`DEVIL_SNOOP_ADDR_BITS-1:0] awaddr;
        logic [2:0]                        awsnoop;
        cache_line_u                       line;
    } wr_snoop_t;

endpackage

`default_nettype wire
